/* axis_frame_buffer_pkg.sv */
`default_nettype none

package axis_frame_buffer_pkg;

  // ****************************************
  // Widths and sizes
  // ****************************************

  localparam int DATA_WIDTH    = 8;
  localparam int ADDR_WIDTH    = 4;
  localparam int FIFO_DEPTH    = 2 ** ADDR_WIDTH;
  localparam int MAX_FRAME_LEN = 8;   // Longer frames are bad.
  localparam int LEN_WIDTH     = 5;
  localparam int COUNT_WIDTH   = 16;

  // ****************************************
  // Types
  // ****************************************

  typedef logic [DATA_WIDTH-1:0]  data_t;
  typedef logic [ADDR_WIDTH:0]    ptr_t;    // Top bit tells full from empty.
  typedef logic [LEN_WIDTH-1:0]   len_t;    // Saturates, never wraps.
  typedef logic [COUNT_WIDTH-1:0] count_t;  // Wraps.

  // One beat of the byte-wide stream.
  typedef struct packed {
    data_t data;
    logic  last;
    logic  user;   // Set on the last beat, the frame is bad.
  } axis_beat_t;

endpackage

`default_nettype wire

/* frame_len_check.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_len_check (
  input  wire                               clk,
  input  wire                               rst,
  input  wire axis_frame_buffer_pkg::axis_beat_t in_beat,
  input  wire                               in_valid,
  output logic                              in_ready,
  output axis_frame_buffer_pkg::axis_beat_t out_beat,
  output logic                              out_valid,
  input  wire                               out_ready
);

  import axis_frame_buffer_pkg::*;

  len_t beat_cnt;    // Beats of the current frame transferred so far.
  logic xfer;
  logic too_long;

  assign xfer = in_valid & out_ready;

  // Count so far plus this beat exceeds the limit.
  assign too_long = (beat_cnt >= len_t'(MAX_FRAME_LEN));

  // ****************************************
  // Stream pass-through
  // ****************************************

  assign in_ready       = out_ready;
  assign out_valid      = in_valid;
  assign out_beat.data  = in_beat.data;
  assign out_beat.last  = in_beat.last;
  assign out_beat.user  = in_beat.user | (in_beat.last & too_long);

  // ****************************************
  // Beat counter
  // ****************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      beat_cnt <= '0;
    end else if (xfer) begin
      if (in_beat.last) begin
        beat_cnt <= '0;                      // Next beat opens a new frame.
      end else if (beat_cnt != '1) begin
        beat_cnt <= beat_cnt + len_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* frame_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_fifo (
  input  wire                               clk,
  input  wire                               rst,
  input  wire axis_frame_buffer_pkg::axis_beat_t in_beat,
  input  wire                               in_valid,
  output logic                              in_ready,
  output axis_frame_buffer_pkg::data_t      out_data,
  output logic                              out_last,
  output logic                              out_valid,
  input  wire                               out_ready,
  output logic                              commit_pulse,
  output logic                              bad_pulse,
  output logic                              overflow_pulse
);

  import axis_frame_buffer_pkg::*;

  typedef struct packed {
    logic  last;
    data_t data;
  } fifo_word_t;

  fifo_word_t mem [FIFO_DEPTH];
  fifo_word_t out_word;

  ptr_t wr_ptr;          // Committed write pointer, end of the last good frame.
  ptr_t wr_ptr_cur;      // Write pointer of the frame being received.
  ptr_t rd_ptr;
  logic drop_frame;      // Rest of the current frame is discarded.

  logic write;
  logic full_cur;
  logic store;
  logic empty;
  logic read;

  // The input never back-pressures; frames that do not fit are dropped.
  assign in_ready = 1'b1;
  assign write    = in_valid & in_ready;

  // No free slot left for the frame in progress.
  assign full_cur = (wr_ptr_cur[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                    (wr_ptr_cur[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

  assign store = write & ~drop_frame & ~full_cur;

  // Only committed beats are visible to the read side.
  assign empty = (rd_ptr == wr_ptr);
  assign read  = (out_ready | ~out_valid) & ~empty;

  // ****************************************
  // Write side
  // ****************************************

  always_ff @(posedge clk) begin
    if (store) begin
      mem[wr_ptr_cur[ADDR_WIDTH-1:0]] <= '{last: in_beat.last, data: in_beat.data};
    end
  end

  always_ff @(posedge clk) begin
    commit_pulse   <= 1'b0;
    bad_pulse      <= 1'b0;
    overflow_pulse <= 1'b0;
    if (rst) begin
      wr_ptr     <= '0;
      wr_ptr_cur <= '0;
      drop_frame <= 1'b0;
    end else if (write) begin
      if (drop_frame || full_cur) begin
        drop_frame <= 1'b1;
        if (in_beat.last) begin
          drop_frame     <= 1'b0;
          wr_ptr_cur     <= wr_ptr;          // Overflow wins over a bad mark.
          overflow_pulse <= 1'b1;
        end
      end else begin
        wr_ptr_cur <= wr_ptr_cur + ptr_t'(1);
        if (in_beat.last) begin
          if (in_beat.user) begin
            wr_ptr_cur <= wr_ptr;            // Roll back the bad frame.
            bad_pulse  <= 1'b1;
          end else begin
            wr_ptr       <= wr_ptr_cur + ptr_t'(1);
            commit_pulse <= 1'b1;
          end
        end
      end
    end
  end

  // ****************************************
  // Read side
  // ****************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (read) begin
      rd_ptr <= rd_ptr + ptr_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      out_word <= mem[rd_ptr[ADDR_WIDTH-1:0]];
    end
  end

  // Output register is refilled when empty or being consumed.
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (out_ready || !out_valid) begin
      out_valid <= ~empty;
    end
  end

  assign out_data = out_word.data;
  assign out_last = out_word.last;

endmodule

`default_nettype wire

/* frame_stats.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_stats (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            commit_pulse,
  input  wire                            bad_pulse,
  input  wire                            overflow_pulse,
  output axis_frame_buffer_pkg::count_t  good_count,
  output axis_frame_buffer_pkg::count_t  bad_count,
  output axis_frame_buffer_pkg::count_t  overflow_count
);

  import axis_frame_buffer_pkg::*;

  // ****************************************
  // Frame counters
  // ****************************************

  // All three wrap silently at the top of count_t.
  always_ff @(posedge clk) begin
    if (rst) begin
      good_count <= '0;
    end else if (commit_pulse) begin
      good_count <= good_count + count_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bad_count <= '0;
    end else if (bad_pulse) begin
      bad_count <= bad_count + count_t'(1);   // Marked by sender or too long.
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      overflow_count <= '0;
    end else if (overflow_pulse) begin
      overflow_count <= overflow_count + count_t'(1);
    end
  end

endmodule

`default_nettype wire

/* axis_frame_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_frame_buffer (
  input  wire                               clk,
  input  wire                               rst,
  input  wire axis_frame_buffer_pkg::axis_beat_t in_beat,
  input  wire                               in_valid,
  output logic                              in_ready,
  output axis_frame_buffer_pkg::data_t      out_data,
  output logic                              out_last,
  output logic                              out_valid,
  input  wire                               out_ready,
  output axis_frame_buffer_pkg::count_t     good_count,
  output axis_frame_buffer_pkg::count_t     bad_count,
  output axis_frame_buffer_pkg::count_t     overflow_count
);

  import axis_frame_buffer_pkg::*;

  axis_beat_t chk_beat;     // Stream after the length check.
  logic       chk_valid;
  logic       chk_ready;

  logic commit_pulse;
  logic bad_pulse;
  logic overflow_pulse;

  // ****************************************
  // Length check, FIFO, statistics
  // ****************************************

  frame_len_check i_frame_len_check (
    .clk       (clk),
    .rst       (rst),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_beat  (chk_beat),
    .out_valid (chk_valid),
    .out_ready (chk_ready)
  );

  frame_fifo i_frame_fifo (
    .clk            (clk),
    .rst            (rst),
    .in_beat        (chk_beat),
    .in_valid       (chk_valid),
    .in_ready       (chk_ready),
    .out_data       (out_data),
    .out_last       (out_last),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .commit_pulse   (commit_pulse),
    .bad_pulse      (bad_pulse),
    .overflow_pulse (overflow_pulse)
  );

  frame_stats i_frame_stats (
    .clk            (clk),
    .rst            (rst),
    .commit_pulse   (commit_pulse),
    .bad_pulse      (bad_pulse),
    .overflow_pulse (overflow_pulse),
    .good_count     (good_count),
    .bad_count      (bad_count),
    .overflow_count (overflow_count)
  );

endmodule

`default_nettype wire

/* tb_axis_frame_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axis_frame_buffer;

  import axis_frame_buffer_pkg::*;

  localparam int TIMEOUT_CYCLES = 2000;

  typedef enum logic [1:0] {READY_LOW, READY_HIGH, READY_RANDOM} ready_mode_t;

  logic        clk = 1'b0;
  logic        rst;
  axis_beat_t  in_beat;
  logic        in_valid;
  logic        in_ready;
  data_t       out_data;
  logic        out_last;
  logic        out_valid;
  logic        out_ready = 1'b0;
  count_t      good_count;
  count_t      bad_count;
  count_t      overflow_count;

  ready_mode_t ready_mode = READY_LOW;
  ready_mode_t mode_seen;
  logic [31:0] data_lfsr  = 32'h5a43;
  logic [31:0] ready_lfsr = 32'h5a43;
  string       test_name  = "reset";
  logic [7:0]  exp_data [$];   // Bytes of the frames that must come out.
  int          exp_len [$];
  int          exp_good = 0;
  int          exp_bad  = 0;
  int          exp_over = 0;

  axis_frame_buffer i_axis_frame_buffer (
    .clk            (clk),
    .rst            (rst),
    .in_beat        (in_beat),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .out_data       (out_data),
    .out_last       (out_last),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .good_count     (good_count),
    .bad_count      (bad_count),
    .overflow_count (overflow_count)
  );

  always #4 clk = ~clk;

  // The mode is taken at the edge, so a change made after the edge acts one cycle later.
  always @(posedge clk) begin
    mode_seen = ready_mode;
    #1;
    case (mode_seen)
      READY_LOW:  out_ready = 1'b0;
      READY_HIGH: out_ready = 1'b1;
      default: begin
        ready_lfsr = lfsr_next(ready_lfsr);
        out_ready  = ready_lfsr[0];
      end
    endcase
  end

  // ****************************************
  // Helpers
  // ****************************************

  // Taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      data_lfsr = lfsr_next(data_lfsr);
      v = {v[6:0], data_lfsr[0]};
    end
    return v;
  endfunction

  task automatic abort_run(input string msg);
    $display("Error in %s: %s", test_name, msg);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s %s: expected 'h%0h, actual 'h%0h", test_name, name, expected, actual);
      $display("Finished with errors");
      $fatal(1, "Simulation stopped");
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic check_counts();
    check("good_count", 32'(exp_good), 32'(good_count));
    check("bad_count", 32'(exp_bad), 32'(bad_count));
    check("overflow_count", 32'(exp_over), 32'(overflow_count));
  endtask

  // ****************************************
  // Stream tasks
  // ****************************************

  task automatic send_frame(input int length, input logic bad, input logic dropped);
    logic [7:0] b;
    logic [7:0] frame_bytes [$];
    int         waited;
    for (int i = 0; i < length; i++) begin
      b = rand_bits(8);
      in_beat.data = b;
      in_beat.last = (i == length - 1);
      in_beat.user = bad && (i == length - 1);
      in_valid     = 1'b1;
      waited       = 0;
      @(negedge clk);
      while (!in_ready && waited < TIMEOUT_CYCLES) begin
        waited++;
        @(negedge clk);
      end
      if (!in_ready) abort_run("the input never became ready");
      @(posedge clk);
      #1;
      frame_bytes.push_back(b);
    end
    in_valid = 1'b0;
    in_beat  = '0;
    // Dropping for lack of space wins over a bad mark.
    if (dropped) begin
      exp_over++;
    end else if (bad || length > MAX_FRAME_LEN) begin
      exp_bad++;
    end else begin
      exp_good++;
      exp_len.push_back(length);
      foreach (frame_bytes[k]) exp_data.push_back(frame_bytes[k]);
    end
  endtask

  task automatic expect_frame();
    int         n;
    int         waited;
    logic [7:0] b;
    if (exp_len.size() == 0) begin
      abort_run("an output frame was expected but none is queued");
    end else begin
      n = exp_len.pop_front();
      for (int i = 0; i < n; i++) begin
        waited = 0;
        @(negedge clk);
        while (!(out_valid && out_ready) && waited < TIMEOUT_CYCLES) begin
          waited++;
          @(negedge clk);
        end
        if (!(out_valid && out_ready)) abort_run("no output beat arrived in time");
        b = exp_data.pop_front();
        check("out_data", 32'(b), 32'(out_data));
        check("out_last", 32'(i == n - 1), 32'(out_last));
        @(posedge clk);
        #1;
      end
    end
  endtask

  // ****************************************
  // Tests
  // ****************************************

  task automatic test_reset();
    test_name = "reset";
    check("out_valid", 32'd0, 32'(out_valid));
    check("in_ready", 32'd1, 32'(in_ready));
    check_counts();
    ready_mode = READY_HIGH;
    idle_cycles(2);
  endtask

  task automatic test_good_frames();
    test_name = "good_frames";
    for (int len = 1; len <= MAX_FRAME_LEN; len++) begin
      send_frame(len, 1'b0, 1'b0);
      expect_frame();
    end
    check_counts();
  endtask

  task automatic test_bad_frame();
    test_name = "bad_frame";
    send_frame(4, 1'b0, 1'b0);
    expect_frame();
    send_frame(5, 1'b1, 1'b0);
    send_frame(3, 1'b0, 1'b0);
    expect_frame();   // The bad frame in between must not show up here.
    idle_cycles(3);
    check_counts();
    check("out_valid", 32'd0, 32'(out_valid));
  endtask

  task automatic test_too_long();
    test_name = "too_long";
    send_frame(MAX_FRAME_LEN + 1, 1'b0, 1'b0);
    send_frame(15, 1'b0, 1'b0);
    idle_cycles(3);
    check_counts();
    check("out_valid", 32'd0, 32'(out_valid));
    send_frame(3, 1'b0, 1'b0);
    expect_frame();
    check_counts();
  endtask

  // Two full-length frames fill the FIFO, one slot sits in the output register.
  task automatic test_overflow();
    test_name = "overflow";
    ready_mode = READY_LOW;
    idle_cycles(2);
    send_frame(MAX_FRAME_LEN, 1'b0, 1'b0);
    send_frame(MAX_FRAME_LEN, 1'b0, 1'b0);
    send_frame(MAX_FRAME_LEN, 1'b0, 1'b1);
    idle_cycles(3);
    check_counts();
    check("out_valid", 32'd1, 32'(out_valid));
    ready_mode = READY_HIGH;
    expect_frame();
    expect_frame();
    idle_cycles(3);
    check("out_valid", 32'd0, 32'(out_valid));
  endtask

  task automatic test_backpressure();
    int len;
    test_name  = "backpressure";
    ready_mode = READY_RANDOM;
    for (int f = 0; f < 20; f++) begin
      len = int'(rand_bits(3)) + 1;
      send_frame(len, 1'b0, 1'b0);
      expect_frame();
    end
    idle_cycles(3);
    check_counts();
  endtask

  initial begin
    rst      = 1'b1;
    in_beat  = '0;
    in_valid = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    test_reset();
    test_good_frames();
    test_bad_frame();
    test_too_long();
    test_overflow();
    test_backpressure();
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* axis_frame_buffer.f */
axis_frame_buffer_pkg.sv
frame_len_check.sv
frame_fifo.sv
frame_stats.sv
axis_frame_buffer.sv
tb_axis_frame_buffer.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_axis_frame_buffer -f axis_frame_buffer.f &&
  ./obj_dir/Vtb_axis_frame_buffer > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Finished with no errors" sim.log &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
